// ==== Makefile ====
# Verilator simulation of the integer core

sim:
	verilator --binary --timing --assert -f sim.f --top-module cpu_core_tb -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "CHECKS FAILED" sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== bench/cpu_core_asserts.sv ====
// Core bus protocol assertions
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_core_asserts (
   input logic               clk_i,
   input logic               rst_n_i,
   input logic               insn_ready_i,
   input logic               dbus_rd_ready_i,
   input logic               dbus_we_done_i,
   input logic [`CPU_AW-1:0] iaddr_i,
   input logic               ibus_rd_i,
   input logic [`CPU_AW-1:0] addr_i,
   input logic [`CPU_DW-1:0] wdata_i,
   input logic               dbus_rd_i,
   input logic               dbus_we_i
);

   // One memory operation at a time
   a_single_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(dbus_rd_i && dbus_we_i))
      else $error("Load and store strobes are high together");

   a_load_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (dbus_rd_i && !dbus_rd_ready_i) |=> (dbus_rd_i && $stable(addr_i)))
      else $error("Load strobe or address changed while waiting");

   a_store_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (dbus_we_i && !dbus_we_done_i) |=> (dbus_we_i && $stable(addr_i) && $stable(wdata_i)))
      else $error("Store strobe, address or data changed while waiting");

   a_fetch_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (ibus_rd_i && !insn_ready_i) |=> $stable(iaddr_i))
      else $error("Fetch address moved without an accepted word");

endmodule

// ==== bench/cpu_core_tb.sv ====
// Integer core testbench
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_core_tb;

   localparam int BODY_LEN  = 300;
   localparam int MAX_CYCLE = 20000;

   logic               clk_i;
   logic               rst_n_i;
   logic [`CPU_IW-1:0] insn_i;
   logic               insn_ready_i;
   logic [`CPU_DW-1:0] d_i;
   logic               dbus_rd_ready_i;
   logic               dbus_we_done_i;
   logic [`CPU_AW-1:0] iaddr_o;
   logic               ibus_rd_o;
   logic [`CPU_AW-1:0] addr_o;
   logic [`CPU_DW-1:0] d_o;
   logic               dbus_rd_o;
   logic               dbus_we_o;

   logic [31:0] lfsr;
   logic [31:0] prog [$];
   logic [31:0] model_regs [32];
   int          fetch_idx;                 // Next program word to offer
   int          model_idx;
   int          mem_total;
   int          mem_done;
   int          checks;
   int          errors;
   int          cycles;
   logic        dbus_busy;
   int          dbus_wait;

   cpu_core dut0 (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .insn_i          (insn_i),
      .insn_ready_i    (insn_ready_i),
      .d_i             (d_i),
      .dbus_rd_ready_i (dbus_rd_ready_i),
      .dbus_we_done_i  (dbus_we_done_i),
      .iaddr_o         (iaddr_o),
      .ibus_rd_o       (ibus_rd_o),
      .addr_o          (addr_o),
      .d_o             (d_o),
      .dbus_rd_o       (dbus_rd_o),
      .dbus_we_o       (dbus_we_o)
   );

   bind cpu_core cpu_core_asserts asserts0 (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .insn_ready_i    (insn_ready_i),
      .dbus_rd_ready_i (dbus_rd_ready_i),
      .dbus_we_done_i  (dbus_we_done_i),
      .iaddr_i         (iaddr_o),
      .ibus_rd_i       (ibus_rd_o),
      .addr_i          (addr_o),
      .wdata_i         (d_o),
      .dbus_rd_i       (dbus_rd_o),
      .dbus_we_i       (dbus_we_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   //////////////////////////////
   // Random source and program
   //////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] encode(input logic [5:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [15:0] hi);
      return {hi, rs1, rd, op};
   endfunction

   function automatic logic [5:0] pick_op(input logic [3:0] k);
      case (k)
         4'd0:    return cpu_pkg::OP_AND;
         4'd1:    return cpu_pkg::OP_AND_I;
         4'd2:    return cpu_pkg::OP_OR;
         4'd3:    return cpu_pkg::OP_OR_I;
         4'd4:    return cpu_pkg::OP_XOR;
         4'd5:    return cpu_pkg::OP_XOR_I;
         4'd6:    return cpu_pkg::OP_LSL;
         4'd7:    return cpu_pkg::OP_LSL_I;
         4'd8:    return cpu_pkg::OP_LSR;
         4'd9:    return cpu_pkg::OP_LSR_I;
         4'd10:   return cpu_pkg::OP_ASR;
         4'd11:   return cpu_pkg::OP_ASR_I;
         4'd12:   return cpu_pkg::OP_ADD;
         4'd13:   return cpu_pkg::OP_ADD_I;
         4'd14:   return cpu_pkg::OP_SUB;
         default: return cpu_pkg::OP_LDWU;
      endcase
   endfunction

   function automatic bit is_mem_op(input logic [31:0] insn);
      return insn[5:0] == cpu_pkg::OP_LDWU || insn[5:0] == cpu_pkg::OP_STW;
   endfunction

   task automatic build_program();
      logic [31:0] v;
      logic [1:0]  sel;
      logic [5:0]  op;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      // Seed each register with a full 32-bit value
      for (int r = 0; r < 32; r++) begin
         v = rand_bits(32);
         prog.push_back(encode(cpu_pkg::OP_ADD_I, 5'(r), 5'(r), v[31:16]));
         prog.push_back(encode(cpu_pkg::OP_LSL_I, 5'(r), 5'(r), 16'd16));
         prog.push_back(encode(cpu_pkg::OP_OR_I, 5'(r), 5'(r), v[15:0]));
      end
      for (int n = 0; n < BODY_LEN; n++) begin
         if (rand_bits(4) == 32'h0) begin
            op = {1'b1, 5'(rand_bits(5))};            // Above every kept opcode
            rd = 5'(rand_bits(5));
            v  = rand_bits(21);
            prog.push_back(encode(op, rd, v[20:16], v[15:0]));
         end
         sel = 2'(rand_bits(2));
         op  = (sel == 2'd0) ? cpu_pkg::OP_STW : pick_op(4'(rand_bits(4)));
         rd  = 5'(rand_bits(5));
         rs1 = 5'(rand_bits(5));
         v   = rand_bits(16);
         prog.push_back(encode(op, rd, rs1, v[15:0]));
      end
      // Final dump of the whole register file
      for (int r = 0; r < 32; r++) begin
         rs1 = 5'(rand_bits(5));
         v   = rand_bits(16);
         prog.push_back(encode(cpu_pkg::OP_STW, 5'(r), rs1, v[15:0]));
      end
      foreach (prog[i]) begin
         if (is_mem_op(prog[i])) mem_total++;
      end
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic bit is_alu_op(input logic [5:0] op);
      case (op)
         cpu_pkg::OP_AND, cpu_pkg::OP_AND_I, cpu_pkg::OP_OR, cpu_pkg::OP_OR_I,
         cpu_pkg::OP_XOR, cpu_pkg::OP_XOR_I, cpu_pkg::OP_LSL, cpu_pkg::OP_LSL_I,
         cpu_pkg::OP_LSR, cpu_pkg::OP_LSR_I, cpu_pkg::OP_ASR, cpu_pkg::OP_ASR_I,
         cpu_pkg::OP_ADD, cpu_pkg::OP_ADD_I, cpu_pkg::OP_SUB: return 1'b1;
         default:                                           return 1'b0;
      endcase
   endfunction

   // ALU result or memory address of one instruction
   function automatic logic [31:0] model_result(input logic [31:0] insn);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] sx;
      logic [31:0] zx;
      a  = model_regs[insn[15:11]];
      b  = model_regs[insn[20:16]];
      sx = {{16{insn[31]}}, insn[31:16]};
      zx = {16'h0, insn[31:16]};
      case (insn[5:0])
         cpu_pkg::OP_AND:   return a & b;
         cpu_pkg::OP_AND_I: return a & sx;
         cpu_pkg::OP_OR:    return a | b;
         cpu_pkg::OP_OR_I:  return a | zx;
         cpu_pkg::OP_XOR:   return a ^ b;
         cpu_pkg::OP_XOR_I: return a ^ sx;
         cpu_pkg::OP_LSL:   return a << b[4:0];
         cpu_pkg::OP_LSL_I: return a << zx[4:0];
         cpu_pkg::OP_LSR:   return a >> b[4:0];
         cpu_pkg::OP_LSR_I: return a >> zx[4:0];
         cpu_pkg::OP_ASR:   return $signed(a) >>> b[4:0];
         cpu_pkg::OP_ASR_I: return $signed(a) >>> zx[4:0];
         cpu_pkg::OP_ADD:   return a + b;
         cpu_pkg::OP_ADD_I: return a + zx;
         cpu_pkg::OP_SUB:   return a - b;
         default:           return a + sx;
      endcase
   endfunction

   // Runs the model up to the next memory instruction
   task automatic advance_model();
      logic [31:0] insn;
      while (model_idx < prog.size() && !is_mem_op(prog[model_idx])) begin
         insn = prog[model_idx];
         if (is_alu_op(insn[5:0])) model_regs[insn[10:6]] = model_result(insn);
         model_idx++;
      end
   endtask

   //////////////////////////////
   // Checks and bus responders
   //////////////////////////////

   task automatic expect_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_mem(input bit is_store);
      logic [31:0] insn;
      advance_model();
      checks++;
      assert (model_idx < prog.size()) else begin
         errors++;
         $display("A data bus operation finished after the program had ended");
      end
      if (model_idx < prog.size()) begin
         insn = prog[model_idx];
         expect_word("memory opcode", 32'(insn[5:0]),
                     is_store ? 32'(cpu_pkg::OP_STW) : 32'(cpu_pkg::OP_LDWU));
         expect_word("addr_o", addr_o, model_result(insn));
         if (is_store) expect_word("d_o", d_o, model_regs[insn[10:6]]);
         else model_regs[insn[10:6]] = d_i;       // Load data enters the model
         model_idx++;
      end
      mem_done++;
      dbus_busy = 1'b0;
   endtask

   task automatic drive_inputs();
      logic gap;
      gap = (rand_bits(2) == 32'h0);
      insn_ready_i = (fetch_idx < prog.size()) && !gap;
      insn_i       = (fetch_idx < prog.size()) ? prog[fetch_idx] : 32'h0;
      if (dbus_rd_o || dbus_we_o) begin
         if (!dbus_busy) begin
            dbus_busy = 1'b1;
            dbus_wait = int'(rand_bits(2));      // 0 to 3 cycles
         end else if (dbus_wait > 0) begin
            dbus_wait--;
         end
      end
      dbus_rd_ready_i = dbus_rd_o && dbus_busy && dbus_wait == 0;
      dbus_we_done_i  = dbus_we_o && dbus_busy && dbus_wait == 0;
      if (dbus_rd_ready_i) d_i = rand_bits(32);
   endtask

   task automatic sample_outputs();
      // Fetch request drops only while a data access waits
      expect_word("ibus_rd_o", 32'(ibus_rd_o), 32'(!(dbus_busy && dbus_wait != 0)));
      expect_word("iaddr_o", iaddr_o, `CPU_RESET_VECTOR + fetch_idx * `CPU_INSN_BYTES);
      if (ibus_rd_o && insn_ready_i) fetch_idx++;
      if (dbus_we_o && dbus_we_done_i) check_mem(1'b1);
      if (dbus_rd_o && dbus_rd_ready_i) check_mem(1'b0);
   endtask

   initial begin
      lfsr            = 32'h07ba_f670;
      rst_n_i         = 1'b0;
      insn_i          = '0;
      insn_ready_i    = 1'b0;
      d_i             = '0;
      dbus_rd_ready_i = 1'b0;
      dbus_we_done_i  = 1'b0;
      fetch_idx       = 0;
      model_idx       = 0;
      mem_total       = 0;
      mem_done        = 0;
      checks          = 0;
      errors          = 0;
      cycles          = 0;
      dbus_busy       = 1'b0;
      dbus_wait       = 0;
      foreach (model_regs[i]) model_regs[i] = '0;
      build_program();

      repeat (8) @(posedge clk_i);
      #2 rst_n_i = 1'b1;
      @(negedge clk_i);
      expect_word("dbus_rd_o after reset", 32'(dbus_rd_o), 32'h0);
      expect_word("dbus_we_o after reset", 32'(dbus_we_o), 32'h0);
      expect_word("iaddr_o after reset", iaddr_o, `CPU_RESET_VECTOR);
      expect_word("ibus_rd_o after reset", 32'(ibus_rd_o), 32'h1);

      while (mem_done < mem_total && cycles < MAX_CYCLE) begin
         @(posedge clk_i);
         #2;
         drive_inputs();
         @(negedge clk_i);
         sample_outputs();
         cycles++;
      end

      if (mem_done < mem_total) begin
         errors++;
         $display("Timeout: only %0d of %0d memory operations finished", mem_done, mem_total);
      end
      expect_word("words fetched", 32'(fetch_idx), 32'(prog.size()));
      $display("Checks: %0d  Errors: %0d  Cycles: %0d", checks, errors, cycles);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== hdl/cpu_config.svh ====
// Integer core configuration
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_DW 32                       // Data width
`define CPU_AW 32                       // Address width
`define CPU_IW 32                       // Instruction width
`define CPU_REG_AW 5                    // Register file address width

// First fetch address after reset
`define CPU_RESET_VECTOR 32'h0000_0000
`define CPU_INSN_BYTES 4                // PC step per instruction

`endif

// ==== hdl/cpu_core.sv ====
// Three-stage integer core
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_core (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic [`CPU_IW-1:0] insn_i,
   input  logic               insn_ready_i,
   input  logic [`CPU_DW-1:0] d_i,
   input  logic               dbus_rd_ready_i,
   input  logic               dbus_we_done_i,
   output logic [`CPU_AW-1:0] iaddr_o,
   output logic               ibus_rd_o,
   output logic [`CPU_AW-1:0] addr_o,
   output logic [`CPU_DW-1:0] d_o,
   output logic               dbus_rd_o,
   output logic               dbus_we_o
);

   cpu_pkg::fetch_t        fetch;
   cpu_pkg::exec_t         exec;
   cpu_pkg::wb_t           wb;
   logic                   stall;          // Execute freezes fetch and decode
   logic [`CPU_REG_AW-1:0] rs1_addr;
   logic [`CPU_REG_AW-1:0] rs2_addr;
   logic [`CPU_DW-1:0]     rs1_data;
   logic [`CPU_DW-1:0]     rs2_data;

   fetch_stage fetch0 (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .insn_i       (insn_i),
      .insn_ready_i (insn_ready_i),
      .stall_i      (stall),
      .iaddr_o      (iaddr_o),
      .ibus_rd_o    (ibus_rd_o),
      .fetch_o      (fetch)
   );

   decode_stage decode0 (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .fetch_i    (fetch),
      .stall_i    (stall),
      .rs1_addr_o (rs1_addr),
      .rs2_addr_o (rs2_addr),
      .rs1_data_i (rs1_data),
      .rs2_data_i (rs2_data),
      .exec_o     (exec)
   );

   regfile regfile0 (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data),
      .wb_i       (wb)
   );

   execute_stage execute0 (
      .exec_i          (exec),
      .d_i             (d_i),
      .dbus_rd_ready_i (dbus_rd_ready_i),
      .dbus_we_done_i  (dbus_we_done_i),
      .addr_o          (addr_o),
      .d_o             (d_o),
      .dbus_rd_o       (dbus_rd_o),
      .dbus_we_o       (dbus_we_o),
      .stall_o         (stall),
      .wb_o            (wb)
   );

endmodule

// ==== hdl/cpu_pkg.sv ====
// Integer core types
`include "cpu_config.svh"

package cpu_pkg;

   // Opcodes not listed here run as no-ops
   typedef enum logic [5:0] {
      OP_AND   = 6'h02,
      OP_AND_I = 6'h03,
      OP_OR    = 6'h04,
      OP_OR_I  = 6'h05,
      OP_XOR   = 6'h06,
      OP_XOR_I = 6'h07,
      OP_LSL   = 6'h08,
      OP_LSL_I = 6'h09,
      OP_LSR   = 6'h0a,
      OP_LSR_I = 6'h0b,
      OP_ASR   = 6'h0c,
      OP_ASR_I = 6'h0d,
      OP_ADD   = 6'h0e,
      OP_ADD_I = 6'h0f,
      OP_SUB   = 6'h10,
      OP_LDWU  = 6'h1a,
      OP_STW   = 6'h1e
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_NONE = 4'd0,
      ALU_AND  = 4'd1,
      ALU_OR   = 4'd2,
      ALU_XOR  = 4'd3,
      ALU_LSL  = 4'd4,
      ALU_LSR  = 4'd5,
      ALU_ASR  = 4'd6,
      ALU_ADD  = 4'd7,
      ALU_SUB  = 4'd8
   } alu_op_e;

   typedef struct packed {
      logic              valid;
      logic [`CPU_IW-1:0] insn;
   } fetch_t;

   typedef struct packed {
      logic                  valid;
      alu_op_e               alu_op;
      logic [`CPU_DW-1:0]    operand_1;
      logic [`CPU_DW-1:0]    operand_2;
      logic [`CPU_DW-1:0]    store_data; // Register named in rd
      logic                  mem_load;
      logic                  mem_store;
      logic                  wb_en;
      logic [`CPU_REG_AW-1:0] wb_addr;
   } exec_t;

   typedef struct packed {
      logic                  we;
      logic [`CPU_REG_AW-1:0] addr;
      logic [`CPU_DW-1:0]    data;
   } wb_t;

endpackage

// ==== hdl/decode_stage.sv ====
// Instruction decode stage
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_stage (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  cpu_pkg::fetch_t        fetch_i,
   input  logic                   stall_i,
   output logic [`CPU_REG_AW-1:0] rs1_addr_o,
   output logic [`CPU_REG_AW-1:0] rs2_addr_o,
   input  logic [`CPU_DW-1:0]     rs1_data_i,
   input  logic [`CPU_DW-1:0]     rs2_data_i,
   output cpu_pkg::exec_t         exec_o
);

   cpu_pkg::opcode_e       f_opcode;
   logic [`CPU_REG_AW-1:0] f_rd;
   logic [`CPU_REG_AW-1:0] f_rs1;
   logic [`CPU_REG_AW-1:0] f_rs2;
   logic [15:0]            f_imm16;

   cpu_pkg::alu_op_e alu_op;
   logic             mem_load;
   logic             mem_store;
   logic             wb_en;
   logic             use_imm;
   logic             imm_signed;
   logic [`CPU_DW-1:0] imm_oper;

   cpu_pkg::exec_t exec_d;
   cpu_pkg::exec_t exec_q;

   ////////////////////////////////
   // Field split
   ////////////////////////////////

   assign f_opcode = cpu_pkg::opcode_e'(fetch_i.insn[5:0]);
   assign f_rd     = fetch_i.insn[10:6];
   assign f_rs1    = fetch_i.insn[15:11];
   assign f_rs2    = fetch_i.insn[20:16];
   assign f_imm16  = fetch_i.insn[31:16];

   ////////////////////////////////
   // Opcode decode
   ////////////////////////////////

   always_comb begin
      alu_op     = cpu_pkg::ALU_NONE;
      mem_load   = 1'b0;
      mem_store  = 1'b0;
      wb_en      = 1'b1;
      use_imm    = 1'b0;
      imm_signed = 1'b0;
      case (f_opcode)
         cpu_pkg::OP_AND:   alu_op = cpu_pkg::ALU_AND;
         cpu_pkg::OP_OR:    alu_op = cpu_pkg::ALU_OR;
         cpu_pkg::OP_XOR:   alu_op = cpu_pkg::ALU_XOR;
         cpu_pkg::OP_LSL:   alu_op = cpu_pkg::ALU_LSL;
         cpu_pkg::OP_LSR:   alu_op = cpu_pkg::ALU_LSR;
         cpu_pkg::OP_ASR:   alu_op = cpu_pkg::ALU_ASR;
         cpu_pkg::OP_ADD:   alu_op = cpu_pkg::ALU_ADD;
         cpu_pkg::OP_SUB:   alu_op = cpu_pkg::ALU_SUB;
         cpu_pkg::OP_AND_I: begin
            alu_op     = cpu_pkg::ALU_AND;
            use_imm    = 1'b1;
            imm_signed = 1'b1;
         end
         cpu_pkg::OP_XOR_I: begin
            alu_op     = cpu_pkg::ALU_XOR;
            use_imm    = 1'b1;
            imm_signed = 1'b1;
         end
         cpu_pkg::OP_OR_I:  begin
            alu_op  = cpu_pkg::ALU_OR;
            use_imm = 1'b1;
         end
         cpu_pkg::OP_LSL_I: begin
            alu_op  = cpu_pkg::ALU_LSL;
            use_imm = 1'b1;
         end
         cpu_pkg::OP_LSR_I: begin
            alu_op  = cpu_pkg::ALU_LSR;
            use_imm = 1'b1;
         end
         cpu_pkg::OP_ASR_I: begin
            alu_op  = cpu_pkg::ALU_ASR;
            use_imm = 1'b1;
         end
         cpu_pkg::OP_ADD_I: begin
            alu_op  = cpu_pkg::ALU_ADD;
            use_imm = 1'b1;
         end
         // Memory ops form rs1 + simm16 in the adder
         cpu_pkg::OP_LDWU:  begin
            alu_op     = cpu_pkg::ALU_ADD;
            mem_load   = 1'b1;
            use_imm    = 1'b1;
            imm_signed = 1'b1;
         end
         cpu_pkg::OP_STW:   begin
            alu_op     = cpu_pkg::ALU_ADD;
            mem_store  = 1'b1;
            wb_en      = 1'b0;
            use_imm    = 1'b1;
            imm_signed = 1'b1;
         end
         default:           wb_en = 1'b0;       // Unknown opcode is a no-op
      endcase
   end

   assign imm_oper = imm_signed ? {{(`CPU_DW-16){f_imm16[15]}}, f_imm16}
                                : {{(`CPU_DW-16){1'b0}}, f_imm16};

   // Store data comes from rd through the second port
   assign rs1_addr_o = f_rs1;
   assign rs2_addr_o = mem_store ? f_rd : f_rs2;

   always_comb begin
      exec_d.valid      = fetch_i.valid;
      exec_d.alu_op     = alu_op;
      exec_d.operand_1  = rs1_data_i;
      exec_d.operand_2  = use_imm ? imm_oper : rs2_data_i;
      exec_d.store_data = rs2_data_i;
      exec_d.mem_load   = mem_load;
      exec_d.mem_store  = mem_store;
      exec_d.wb_en      = wb_en;
      exec_d.wb_addr    = f_rd;
   end

   ////////////////////////////////
   // Decode to execute register
   ////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         exec_q <= '0;
      end else if (!stall_i) begin
         exec_q <= exec_d;
      end
   end

   assign exec_o = exec_q;

endmodule

// ==== hdl/execute_stage.sv ====
// Execute and writeback stage
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute_stage (
   input  cpu_pkg::exec_t     exec_i,
   input  logic [`CPU_DW-1:0] d_i,
   input  logic               dbus_rd_ready_i,
   input  logic               dbus_we_done_i,
   output logic [`CPU_AW-1:0] addr_o,
   output logic [`CPU_DW-1:0] d_o,
   output logic               dbus_rd_o,
   output logic               dbus_we_o,
   output logic               stall_o,
   output cpu_pkg::wb_t       wb_o
);

   logic                 is_lsl;
   logic [`CPU_DW-1:0]   shift_lsw;
   logic [`CPU_DW-1:0]   shift_msw;
   logic [2*`CPU_DW-1:0] shift_wide;
   logic [`CPU_DW-1:0]   shift_right;
   logic [`CPU_DW-1:0]   shift_res;

   logic                 adder_sub;
   logic [`CPU_DW-1:0]   adder_op2;
   logic [`CPU_DW-1:0]   adder_sum;

   logic [`CPU_DW-1:0]   alu_res;

   function automatic logic [`CPU_DW-1:0] reverse_bits(input logic [`CPU_DW-1:0] a);
      logic [`CPU_DW-1:0] r;
      for (int i = 0; i < `CPU_DW; i++) begin
         r[`CPU_DW-1-i] = a[i];
      end
      return r;
   endfunction

   ////////////////////////////////
   // Shifter
   ////////////////////////////////

   // Left shift is a right shift of the mirrored word
   assign is_lsl      = (exec_i.alu_op == cpu_pkg::ALU_LSL);
   assign shift_lsw   = is_lsl ? reverse_bits(exec_i.operand_1) : exec_i.operand_1;
   assign shift_msw   = (exec_i.alu_op == cpu_pkg::ALU_ASR) ?
                        {`CPU_DW{exec_i.operand_1[`CPU_DW-1]}} : '0;
   assign shift_wide  = {shift_msw, shift_lsw} >> exec_i.operand_2[4:0];
   assign shift_right = shift_wide[`CPU_DW-1:0];
   assign shift_res   = is_lsl ? reverse_bits(shift_right) : shift_right;

   ////////////////////////////////
   // Adder
   ////////////////////////////////

   assign adder_sub = (exec_i.alu_op == cpu_pkg::ALU_SUB);
   assign adder_op2 = adder_sub ? ~exec_i.operand_2 : exec_i.operand_2;
   assign adder_sum = exec_i.operand_1 + adder_op2 + `CPU_DW'(adder_sub);  // +1 completes negate

   always_comb begin
      case (exec_i.alu_op)
         cpu_pkg::ALU_AND: alu_res = exec_i.operand_1 & exec_i.operand_2;
         cpu_pkg::ALU_OR:  alu_res = exec_i.operand_1 | exec_i.operand_2;
         cpu_pkg::ALU_XOR: alu_res = exec_i.operand_1 ^ exec_i.operand_2;
         cpu_pkg::ALU_LSL,
         cpu_pkg::ALU_LSR,
         cpu_pkg::ALU_ASR: alu_res = shift_res;
         cpu_pkg::ALU_ADD,
         cpu_pkg::ALU_SUB: alu_res = adder_sum;
         default:          alu_res = '0;
      endcase
   end

   ////////////////////////////////
   // Data bus and writeback
   ////////////////////////////////

   assign addr_o    = adder_sum;            // Memory ops always add
   assign d_o       = exec_i.store_data;
   assign dbus_rd_o = exec_i.valid & exec_i.mem_load;
   assign dbus_we_o = exec_i.valid & exec_i.mem_store;

   // Hold the pipe until the bus answers
   assign stall_o = (dbus_rd_o & ~dbus_rd_ready_i) | (dbus_we_o & ~dbus_we_done_i);

   assign wb_o.we   = exec_i.valid & exec_i.wb_en & ~stall_o;
   assign wb_o.addr = exec_i.wb_addr;
   assign wb_o.data = exec_i.mem_load ? d_i : alu_res;

endmodule

// ==== hdl/fetch_stage.sv ====
// Instruction fetch stage
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_stage (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic [`CPU_IW-1:0]   insn_i,
   input  logic                 insn_ready_i,
   input  logic                 stall_i,
   output logic [`CPU_AW-1:0]   iaddr_o,
   output logic                 ibus_rd_o,
   output cpu_pkg::fetch_t      fetch_o
);

   logic [`CPU_AW-1:0] pc_q;
   logic               accept;
   cpu_pkg::fetch_t    fetch_q;

   ////////////////////////////////
   // Program counter
   ////////////////////////////////

   // No request while execute holds the pipe
   assign ibus_rd_o = ~stall_i;
   assign accept    = insn_ready_i & ibus_rd_o;
   assign iaddr_o   = pc_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_q <= `CPU_RESET_VECTOR;
      end else if (accept) begin
         pc_q <= pc_q + `CPU_AW'(`CPU_INSN_BYTES);  // Straight-line only
      end
   end

   ////////////////////////////////
   // Fetch to decode register
   ////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         fetch_q <= '0;
      end else if (!stall_i) begin
         // Bubble when the bus has no word this cycle
         fetch_q.valid <= accept;
         fetch_q.insn  <= insn_i;
      end
   end

   assign fetch_o = fetch_q;

endmodule

// ==== hdl/regfile.sv ====
// General purpose register file
`timescale 1ns/1ps
`include "cpu_config.svh"

module regfile (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic [`CPU_REG_AW-1:0] rs1_addr_i,
   input  logic [`CPU_REG_AW-1:0] rs2_addr_i,
   output logic [`CPU_DW-1:0]     rs1_data_o,
   output logic [`CPU_DW-1:0]     rs2_data_o,
   input  cpu_pkg::wb_t           wb_i
);

   localparam int NREGS = 1 << `CPU_REG_AW;

   logic [`CPU_DW-1:0] regs [NREGS];

   // r0 is an ordinary register here
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_i.we) begin
         regs[wb_i.addr] <= wb_i.data;
      end
   end

   ////////////////////////////////
   // Read ports with write-through
   ////////////////////////////////

   function automatic logic [`CPU_DW-1:0] read_port(input logic [`CPU_REG_AW-1:0] addr,
                                                    input logic [`CPU_DW-1:0]     stored,
                                                    input cpu_pkg::wb_t           wb);
      // Result retiring this cycle wins over the array
      return (wb.we && wb.addr == addr) ? wb.data : stored;
   endfunction

   assign rs1_data_o = read_port(rs1_addr_i, regs[rs1_addr_i], wb_i);
   assign rs2_data_o = read_port(rs2_addr_i, regs[rs2_addr_i], wb_i);

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/regfile.sv
hdl/execute_stage.sv
hdl/cpu_core.sv
bench/cpu_core_asserts.sv
bench/cpu_core_tb.sv
